//--- hdl/cpu_pkg.sv
// Processor-side definitions for the load/store path
// Data and address width, access size codes and exception vectors
package cpu_pkg;

   // Data path and effective address share one width
   localparam int data_w = 32;

   // Access size codes as carried on op_size
   // Code 0 is not issued by the core
   localparam logic [1:0] size_byte = 2'd1;
   localparam logic [1:0] size_half = 2'd2;
   localparam logic [1:0] size_word = 2'd3;

   // Exception vectors returned on res_vector
   localparam int vect_w = 8;

   // Halfword at an odd address or word off a 4-byte boundary
   localparam logic [vect_w-1:0] vec_misalign = 8'h20;

   // Address outside the mapped data memory
   localparam logic [vect_w-1:0] vec_access_fault = 8'h24;

endpackage

//--- hdl/mem_pkg.sv
// Geometry of the byte-banked data memory
// Bank count, per-bank address width and mapped size
package mem_pkg;

   // One bank per byte lane of the 32-bit word
   localparam int n_banks = 4;

   // Each bank holds 2**bank_aw bytes, one per word index
   localparam int bank_aw = 8;

   // Bytes reachable through the banks
   // Anything from here upward answers with a slave error
   localparam int mem_bytes = n_banks * (2 ** bank_aw);

endpackage

//--- hdl/sram_bank.sv
// Byte-wide single-port memory bank with synchronous read
// Write when enabled with we high, read when enabled with we low
module sram_bank
   import mem_pkg::*;
(
   input  logic                  clk,
   input  logic                  en,
   input  logic                  we,
   input  logic [bank_aw-1:0]    addr,
   input  logic [7:0]            wdata,
   output logic [7:0]            rdata
);

   logic [7:0] mem [2**bank_aw];

   // A write leaves rdata at its previous value
   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            mem[addr] <= wdata;
         end else begin
            rdata <= mem[addr];
         end
      end
   end

endmodule

//--- hdl/bank_router.sv
// APB slave front end of the data memory
// Address decode, per-bank enables and write strobes, range check
module bank_router
   import cpu_pkg::*;
   import mem_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  psel,
   input  logic                  penable,
   input  logic [data_w-1:0]     paddr,
   input  logic                  pwrite,
   input  logic [n_banks-1:0]    pstrb,
   input  logic                  pready,
   output logic [n_banks-1:0]    bank_en,
   output logic [n_banks-1:0]    bank_we,
   output logic [bank_aw-1:0]    bank_addr,
   output logic                  xfer_done,
   output logic                  xfer_err
);

   logic acc_seen;
   logic first_acc;
   logic mapped;

   // First access cycle of a transfer
   // acc_seen keeps the banks from firing twice if the response is late
   assign first_acc = psel && penable && !pready && !acc_seen;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         acc_seen <= 1'b0;
      end else if (pready || !psel) begin
         acc_seen <= 1'b0;
      end else if (first_acc) begin
         acc_seen <= 1'b1;
      end
   end

   // Mapped range starts at zero
   assign mapped = paddr < data_w'(mem_bytes);

   // Word index drops the lane bits
   assign bank_addr = paddr[$clog2(n_banks) +: bank_aw];

   // Writes touch only the strobed lanes, reads fetch the whole word
   always_comb begin
      bank_en = '0;
      bank_we = '0;
      if (first_acc && mapped) begin
         if (pwrite) begin
            bank_en = pstrb;
            bank_we = pstrb;
         end else begin
            bank_en = '1;
         end
      end
   end

   // Completion is announced to the merger in the same cycle as the bank access
   assign xfer_done = first_acc;
   assign xfer_err  = first_acc && !mapped;

endmodule

//--- hdl/lane_merge.sv
// Read-side merger of the data memory
// Joins the bank bytes into prdata and drives the APB response
module lane_merge
   import cpu_pkg::*;
   import mem_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        xfer_done,
   input  logic                        xfer_err,
   input  logic [n_banks-1:0][7:0]     bank_rdata,
   output logic [data_w-1:0]           prdata,
   output logic                        pready,
   output logic                        pslverr
);

   // The banks read on the same edge that registers the completion
   // So the bytes and pready line up in the second access cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pready  <= 1'b0;
         pslverr <= 1'b0;
      end else begin
         // Each flag is a single-cycle pulse
         pready  <= xfer_done;
         pslverr <= xfer_err;
      end
   end

   // Bank i supplies byte lane i of the word
   // An unmapped access drove no bank, so stale bytes are masked out
   for (genvar i = 0; i < n_banks; i++) begin : g_lane
      assign prdata[8*i +: 8] = bank_rdata[i] & {8{!pslverr}};
   end

endmodule

//--- hdl/ldst_unit.sv
// Load/store unit acting as APB master towards the data memory
// Effective address, alignment check, byte lanes and load extension
module ldst_unit
   import cpu_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   // Issue side
   input  logic                  op_valid,
   output logic                  op_ready,
   input  logic                  op_load,
   input  logic                  op_sign_ext,
   input  logic [1:0]            op_size,
   input  logic [data_w-1:0]     op_base,
   input  logic [data_w-1:0]     op_offset,
   input  logic [data_w-1:0]     op_wdata,
   // Result side
   output logic                  res_valid,
   input  logic                  res_ready,
   output logic [data_w-1:0]     res_data,
   output logic                  res_exc,
   output logic [vect_w-1:0]     res_vector,
   // APB master
   output logic                  psel,
   output logic                  penable,
   output logic [data_w-1:0]     paddr,
   output logic                  pwrite,
   output logic [data_w-1:0]     pwdata,
   output logic [data_w/8-1:0]   pstrb,
   input  logic [data_w-1:0]     prdata,
   input  logic                  pready,
   input  logic                  pslverr
);

   logic [data_w-1:0]   ea;
   logic                misalign;
   logic                accept;
   logic                bus_done;
   logic [data_w/8-1:0] strb_base;
   logic [data_w/8-1:0] op_strb;
   logic [data_w-1:0]   op_wlanes;
   logic [1:0]          size_q;
   logic                sign_q;
   logic [data_w-1:0]   rd_shift;
   logic [data_w-1:0]   load_data;

   // Effective address is base plus offset, wrapping at 32 bits
   assign ea = op_base + op_offset;

   // Byte accesses are always aligned
   assign misalign = (op_size == size_half && ea[0]) ||
                     (op_size == size_word && ea[1:0] != 2'b00);

   // Only one operation in flight, and a held result blocks the next one
   assign op_ready = !psel && !res_valid;
   assign accept   = op_valid && op_ready;

   // The slave answers in the access phase
   assign bus_done = psel && penable && pready;

   // Strobe pattern for lane 0, shifted up to the addressed lane below
   always_comb begin
      case (op_size)
         size_byte: strb_base = {{(data_w/8-1){1'b0}}, 1'b1};
         size_half: strb_base = {{(data_w/8-2){1'b0}}, 2'b11};
         default:   strb_base = '1;
      endcase
   end

   assign op_strb = strb_base << ea[1:0];

   // Store data is copied onto every lane so the strobes alone pick the target
   always_comb begin
      case (op_size)
         size_byte: op_wlanes = {(data_w/8){op_wdata[7:0]}};
         size_half: op_wlanes = {(data_w/16){op_wdata[15:0]}};
         default:   op_wlanes = op_wdata;
      endcase
   end

   // Bring the addressed byte or halfword down to bit 0
   assign rd_shift = prdata >> {paddr[1:0], 3'b000};

   // Zero or sign extension of the selected lanes
   always_comb begin
      case (size_q)
         size_byte: load_data = {{(data_w-8){sign_q & rd_shift[7]}}, rd_shift[7:0]};
         size_half: load_data = {{(data_w-16){sign_q & rd_shift[15]}}, rd_shift[15:0]};
         default:   load_data = rd_shift;
      endcase
   end

   // Handshake and APB phase flags
   // Sequence for a bus operation, one line per cycle after the accepting edge
   // setup, first access, second access with pready, then res_valid
   // Counting the accepting cycle as the first, res_valid is up in the fifth
   // A misaligned op raises res_valid right after the accepting edge
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         psel      <= 1'b0;
         penable   <= 1'b0;
         res_valid <= 1'b0;
      end else begin
         if (accept && !misalign) begin
            psel <= 1'b1;
         end else if (bus_done) begin
            psel <= 1'b0;
         end

         // Access phase always follows exactly one setup cycle
         if (psel && !penable) begin
            penable <= 1'b1;
         end else if (bus_done) begin
            penable <= 1'b0;
         end

         if ((accept && misalign) || bus_done) begin
            res_valid <= 1'b1;
         end else if (res_ready) begin
            res_valid <= 1'b0;
         end
      end
   end

   // Transfer attributes are captured once and stay put until pready
   always_ff @(posedge clk) begin
      if (accept && !misalign) begin
         paddr  <= ea;
         pwrite <= !op_load;
         pwdata <= op_wlanes;
         // APB reads carry no strobes
         pstrb  <= op_load ? '0 : op_strb;
         size_q <= op_size;
         sign_q <= op_sign_ext;
      end
   end

   // Result payload, held while res_ready is low
   always_ff @(posedge clk) begin
      if (accept && misalign) begin
         res_data   <= '0;
         res_exc    <= 1'b1;
         res_vector <= vec_misalign;
      end else if (bus_done) begin
         res_exc    <= pslverr;
         res_vector <= pslverr ? vec_access_fault : '0;
         // Stores and faulted loads return zero
         res_data   <= (pwrite || pslverr) ? '0 : load_data;
      end
   end

endmodule

//--- hdl/data_mem_top.sv
// Top level of the data-memory path
// Load/store unit, APB router, byte bank array and read merger
module data_mem_top
   import cpu_pkg::*;
   import mem_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   // Issue side
   input  logic                  op_valid,
   output logic                  op_ready,
   input  logic                  op_load,
   input  logic                  op_sign_ext,
   input  logic [1:0]            op_size,
   input  logic [data_w-1:0]     op_base,
   input  logic [data_w-1:0]     op_offset,
   input  logic [data_w-1:0]     op_wdata,
   // Result side
   output logic                  res_valid,
   input  logic                  res_ready,
   output logic [data_w-1:0]     res_data,
   output logic                  res_exc,
   output logic [vect_w-1:0]     res_vector
);

   // APB between the unit and the memory
   logic                      psel;
   logic                      penable;
   logic [data_w-1:0]         paddr;
   logic                      pwrite;
   logic [data_w-1:0]         pwdata;
   logic [n_banks-1:0]        pstrb;
   logic [data_w-1:0]         prdata;
   logic                      pready;
   logic                      pslverr;

   // Bank side
   logic [n_banks-1:0]        bank_en;
   logic [n_banks-1:0]        bank_we;
   logic [bank_aw-1:0]        bank_addr;
   logic [n_banks-1:0][7:0]   bank_rdata;
   logic                      xfer_done;
   logic                      xfer_err;

   ldst_unit u_ldst (
      .clk         (clk),
      .rst_n       (rst_n),
      .op_valid    (op_valid),
      .op_ready    (op_ready),
      .op_load     (op_load),
      .op_sign_ext (op_sign_ext),
      .op_size     (op_size),
      .op_base     (op_base),
      .op_offset   (op_offset),
      .op_wdata    (op_wdata),
      .res_valid   (res_valid),
      .res_ready   (res_ready),
      .res_data    (res_data),
      .res_exc     (res_exc),
      .res_vector  (res_vector),
      .psel        (psel),
      .penable     (penable),
      .paddr       (paddr),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .pstrb       (pstrb),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr)
   );

   bank_router u_router (
      .clk       (clk),
      .rst_n     (rst_n),
      .psel      (psel),
      .penable   (penable),
      .paddr     (paddr),
      .pwrite    (pwrite),
      .pstrb     (pstrb),
      .pready    (pready),
      .bank_en   (bank_en),
      .bank_we   (bank_we),
      .bank_addr (bank_addr),
      .xfer_done (xfer_done),
      .xfer_err  (xfer_err)
   );

   // Write data arrives already replicated, so lane i takes byte i of pwdata
   for (genvar i = 0; i < n_banks; i++) begin : g_bank
      sram_bank u_bank (
         .clk   (clk),
         .en    (bank_en[i]),
         .we    (bank_we[i]),
         .addr  (bank_addr),
         .wdata (pwdata[8*i +: 8]),
         .rdata (bank_rdata[i])
      );
   end

   lane_merge u_merge (
      .clk        (clk),
      .rst_n      (rst_n),
      .xfer_done  (xfer_done),
      .xfer_err   (xfer_err),
      .bank_rdata (bank_rdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr)
   );

endmodule

//--- verification/tb_vectors.svh
// Directed operations for the data-memory testbench
// Row layout, table storage and the task that fills it
`ifndef tb_vectors_svh
`define tb_vectors_svh

   // One directed operation and the result it must produce
   typedef struct packed {
      logic        load;
      logic [1:0]  size;
      logic        sext;
      logic [31:0] base;
      logic [31:0] offset;
      logic [31:0] wdata;
      logic [31:0] exp_data;
      logic        exp_exc;
      logic [7:0]  exp_vec;
   } vec_t;

   localparam int n_vec = 21;

   vec_t vec_tbl [n_vec];

   // Columns are load, size, sext, base, offset, wdata, exp_data, exp_exc and exp_vec
   // Rows build on each other, so the order matters
   task automatic fill_table();
      // Word store and word load at 0x10
      vec_tbl[0]  = '{1'b0, size_word, 1'b0, 32'h10, 32'h0, 32'h89ab_cdef, 32'h0, 1'b0, 8'h00};
      vec_tbl[1]  = '{1'b1, size_word, 1'b0, 32'h10, 32'h0, 32'h0, 32'h89ab_cdef, 1'b0, 8'h00};
      // Byte store into lane 1 only with the upper store bits ignored
      vec_tbl[2]  = '{1'b0, size_byte, 1'b0, 32'h10, 32'h1, 32'h1234_56a5, 32'h0, 1'b0, 8'h00};
      vec_tbl[3]  = '{1'b1, size_word, 1'b0, 32'h10, 32'h0, 32'h0, 32'h89ab_a5ef, 1'b0, 8'h00};
      vec_tbl[4]  = '{1'b1, size_byte, 1'b0, 32'h11, 32'h0, 32'h0, 32'h0000_00a5, 1'b0, 8'h00};
      vec_tbl[5]  = '{1'b1, size_byte, 1'b1, 32'h11, 32'h0, 32'h0, 32'hffff_ffa5, 1'b0, 8'h00};
      // Halfword store into the upper two lanes
      vec_tbl[6]  = '{1'b0, size_half, 1'b0, 32'h0, 32'h12, 32'hcafe_7e01, 32'h0, 1'b0, 8'h00};
      vec_tbl[7]  = '{1'b1, size_half, 1'b1, 32'h12, 32'h0, 32'h0, 32'h0000_7e01, 1'b0, 8'h00};
      vec_tbl[8]  = '{1'b1, size_half, 1'b1, 32'h10, 32'h0, 32'h0, 32'hffff_a5ef, 1'b0, 8'h00};
      vec_tbl[9]  = '{1'b1, size_half, 1'b0, 32'h10, 32'h0, 32'h0, 32'h0000_a5ef, 1'b0, 8'h00};
      // Misaligned stores must leave the word at 0x10 alone
      vec_tbl[10] = '{1'b0, size_half, 1'b0, 32'h11, 32'h0, 32'hffff, 32'h0, 1'b1, vec_misalign};
      vec_tbl[11] = '{1'b0, size_word, 1'b0, 32'h12, 32'h0, 32'h0, 32'h0, 1'b1, vec_misalign};
      vec_tbl[12] = '{1'b1, size_word, 1'b0, 32'h10, 32'h0, 32'h0, 32'h7e01_a5ef, 1'b0, 8'h00};
      // Just past the mapped range for a load and a store
      vec_tbl[13] = '{1'b1, size_word, 1'b0, 32'h3fc, 32'h4, 32'h0, 32'h0, 1'b1, vec_access_fault};
      vec_tbl[14] = '{1'b0, size_byte, 1'b0, 32'h400, 32'h0, 32'h77, 32'h0, 1'b1, vec_access_fault};
      // Negative offset wraps back into the mapped range
      vec_tbl[15] = '{1'b1, size_word, 1'b0, 32'h20, 32'hffff_fff0, 32'h0, 32'h7e01_a5ef, 1'b0,
                      8'h00};
      vec_tbl[16] = '{1'b1, size_byte, 1'b1, 32'h13, 32'h0, 32'h0, 32'h0000_007e, 1'b0, 8'h00};
      vec_tbl[17] = '{1'b1, size_half, 1'b0, 32'h13, 32'h0, 32'h0, 32'h0, 1'b1, vec_misalign};
      // Last mapped byte
      vec_tbl[18] = '{1'b0, size_byte, 1'b0, 32'h3ff, 32'h0, 32'h80, 32'h0, 1'b0, 8'h00};
      vec_tbl[19] = '{1'b1, size_byte, 1'b1, 32'h3ff, 32'h0, 32'h0, 32'hffff_ff80, 1'b0, 8'h00};
      vec_tbl[20] = '{1'b1, size_word, 1'b0, 32'hffff_fff0, 32'h0, 32'h0, 32'h0, 1'b1,
                      vec_access_fault};
   endtask

`endif

//--- verification/tb_data_mem.sv
// Testbench for the data-memory path
// Directed table, random loads and stores against a byte model
// Checks results, exceptions, bus latency and result back-pressure
module tb_data_mem
   import cpu_pkg::*;
   import mem_pkg::*;
();

   // Longest wait for any handshake in clock cycles
   localparam int wait_limit = 20;

   logic              clk;
   logic              rst_n;
   logic              op_valid;
   logic              op_ready;
   logic              op_load;
   logic              op_sign_ext;
   logic [1:0]        op_size;
   logic [31:0]       op_base;
   logic [31:0]       op_offset;
   logic [31:0]       op_wdata;
   logic              res_valid;
   logic              res_ready;
   logic [31:0]       res_data;
   logic              res_exc;
   logic [7:0]        res_vector;

   integer            seed;
   int                errors;
   int                timeouts;

   // Byte image of the mapped memory for the random phase
   logic [7:0]        ref_mem [mem_bytes];

   `include "tb_vectors.svh"

   data_mem_top i_data_mem_top (
      .clk         (clk),
      .rst_n       (rst_n),
      .op_valid    (op_valid),
      .op_ready    (op_ready),
      .op_load     (op_load),
      .op_sign_ext (op_sign_ext),
      .op_size     (op_size),
      .op_base     (op_base),
      .op_offset   (op_offset),
      .op_wdata    (op_wdata),
      .res_valid   (res_valid),
      .res_ready   (res_ready),
      .res_data    (res_data),
      .res_exc     (res_exc),
      .res_vector  (res_vector)
   );

   always #50 clk = ~clk;

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
   endtask

   // Issues one operation, checks its result, then holds res_ready low for stall cycles
   // Called and left at a falling edge
   task automatic run_op(input logic load, input logic [1:0] size, input logic sext,
                         input logic [31:0] base, input logic [31:0] offset,
                         input logic [31:0] wdata, input logic [31:0] exp_data,
                         input logic exp_exc, input logic [7:0] exp_vec, input int stall);
      int          waited;
      int          edges;
      int          exp_edges;
      logic [31:0] held_data;
      logic        held_exc;
      logic [7:0]  held_vec;
      op_valid    = 1'b1;
      op_load     = load;
      op_size     = size;
      op_sign_ext = sext;
      op_base     = base;
      op_offset   = offset;
      op_wdata    = wdata;
      res_ready   = (stall == 0);
      waited = 0;
      while (!op_ready && waited < wait_limit) begin
         @(negedge clk);
         waited++;
      end
      if (!op_ready) begin
         $display("Timeout at %0t: op_ready did not rise within %0d cycles", $time, wait_limit);
         timeouts++;
         op_valid = 1'b0;
         return;
      end
      // The next rising edge accepts the operation
      @(negedge clk);
      op_valid = 1'b0;
      edges = 1;
      while (!res_valid && edges < wait_limit) begin
         @(negedge clk);
         edges++;
      end
      if (!res_valid) begin
         $display("Timeout at %0t: no result within %0d cycles of acceptance", $time, wait_limit);
         timeouts++;
         return;
      end
      // A bus op takes five cycles counting the accepting one, which is four edges after it
      exp_edges = (exp_exc && exp_vec == vec_misalign) ? 1 : 4;
      if (edges != exp_edges) report_mismatch("result latency", edges, exp_edges);
      if (res_data !== exp_data) report_mismatch("res_data", res_data, exp_data);
      if (res_exc !== exp_exc) report_mismatch("res_exc", res_exc, exp_exc);
      if (exp_exc && res_vector !== exp_vec) report_mismatch("res_vector", res_vector, exp_vec);
      held_data = res_data;
      held_exc  = res_exc;
      held_vec  = res_vector;
      // While res_ready is low nothing may move
      for (int k = 0; k < stall; k++) begin
         @(negedge clk);
         if (res_valid !== 1'b1) report_mismatch("res_valid", res_valid, 1'b1);
         if (res_data !== held_data) report_mismatch("res_data", res_data, held_data);
         if (res_exc !== held_exc) report_mismatch("res_exc", res_exc, held_exc);
         if (res_vector !== held_vec) report_mismatch("res_vector", res_vector, held_vec);
         if (op_ready !== 1'b0) report_mismatch("op_ready", op_ready, 1'b0);
      end
      res_ready = 1'b1;
      @(negedge clk);
      if (res_valid !== 1'b0) report_mismatch("res_valid", res_valid, 1'b0);
   endtask

   // Little-endian byte update of the model
   task automatic write_ref(input logic [31:0] addr, input logic [1:0] size,
                            input logic [31:0] wdata);
      ref_mem[addr[9:0]] = wdata[7:0];
      if (size != size_byte) ref_mem[addr[9:0] + 1] = wdata[15:8];
      if (size == size_word) begin
         ref_mem[addr[9:0] + 2] = wdata[23:16];
         ref_mem[addr[9:0] + 3] = wdata[31:24];
      end
   endtask

   function automatic logic [31:0] predict_load(input logic [31:0] addr, input logic [1:0] size,
                                                input logic sext);
      logic [9:0] a;
      a = addr[9:0];
      case (size)
         size_byte: return {{24{sext & ref_mem[a][7]}}, ref_mem[a]};
         size_half: return {{16{sext & ref_mem[a + 1][7]}}, ref_mem[a + 1], ref_mem[a]};
         default:   return {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
      endcase
   endfunction

   // Initial word for the random window that changes with every address bit
   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return (addr * 32'h9e37_79b9) ^ {addr[7:0], addr[15:8], addr[23:16], addr[31:24]};
   endfunction

   // One random load or store in the window at 0x200 that is now and then misaligned or unmapped
   task automatic random_op();
      logic        load;
      logic        sext;
      logic [1:0]  size;
      logic [31:0] r;
      logic [31:0] mask;
      logic [31:0] addr;
      logic [31:0] off;
      logic [31:0] wdata;
      logic [31:0] exp_data;
      logic        exc;
      logic [7:0]  vec;
      r     = $random(seed);
      load  = r[2];
      sext  = r[3];
      size  = (r[1:0] == 2'd0) ? size_word : r[1:0];
      mask  = (size == size_word) ? 32'h3 : (size == size_half) ? 32'h1 : 32'h0;
      addr  = 32'h200 + ($random(seed) & 32'h3f);
      if (r[5:4] != 2'b00) addr = addr & ~mask;
      if (r[9:6] == 4'd0) addr = addr + 32'h400;
      off   = $random(seed);
      wdata = $random(seed);
      exc      = 1'b1;
      exp_data = 32'h0;
      if ((addr & mask) != 0) begin
         vec = vec_misalign;
      end else if (addr >= mem_bytes) begin
         vec = vec_access_fault;
      end else begin
         exc = 1'b0;
         vec = 8'h00;
         if (load) begin
            exp_data = predict_load(addr, size, sext);
         end else begin
            write_ref(addr, size, wdata);
         end
      end
      run_op(load, size, sext, addr - off, off, wdata, exp_data, exc, vec,
             (r[12:10] == 3'd0) ? 2 : 0);
   endtask

   initial begin
      logic [31:0] addr;
      seed        = 32'hebaf_d715;
      errors      = 0;
      timeouts    = 0;
      clk         = 1'b0;
      rst_n       = 1'b0;
      op_valid    = 1'b0;
      op_load     = 1'b0;
      op_sign_ext = 1'b0;
      op_size     = size_word;
      op_base     = 32'h0;
      op_offset   = 32'h0;
      op_wdata    = 32'h0;
      res_ready   = 1'b1;
      fill_table();
      repeat (3) @(negedge clk);
      // Idle state straight out of reset
      if (op_ready !== 1'b1) report_mismatch("op_ready", op_ready, 1'b1);
      if (res_valid !== 1'b0) report_mismatch("res_valid", res_valid, 1'b0);
      if (i_data_mem_top.psel !== 1'b0) report_mismatch("psel", i_data_mem_top.psel, 1'b0);
      if (i_data_mem_top.penable !== 1'b0) report_mismatch("penable", i_data_mem_top.penable, 0);
      if (i_data_mem_top.pready !== 1'b0) report_mismatch("pready", i_data_mem_top.pready, 1'b0);
      if (i_data_mem_top.pslverr !== 1'b0) report_mismatch("pslverr", i_data_mem_top.pslverr, 0);
      rst_n = 1'b1;
      @(negedge clk);
      // Every fourth row also exercises back-pressure
      for (int i = 0; i < n_vec && timeouts == 0; i++) begin
         run_op(vec_tbl[i].load, vec_tbl[i].size, vec_tbl[i].sext, vec_tbl[i].base,
                vec_tbl[i].offset, vec_tbl[i].wdata, vec_tbl[i].exp_data,
                vec_tbl[i].exp_exc, vec_tbl[i].exp_vec, (i % 4 == 3) ? 3 : 0);
      end
      // Known contents for the random window before any random load
      for (int i = 0; i < 16 && timeouts == 0; i++) begin
         addr = 32'h200 + 4 * i;
         write_ref(addr, size_word, fill_word(addr));
         run_op(1'b0, size_word, 1'b0, addr, 32'h0, fill_word(addr), 32'h0, 1'b0, 8'h00, 0);
      end
      for (int i = 0; i < 200 && timeouts == 0; i++) begin
         random_op();
      end
      $display("Value errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- vlog.f
+incdir+verification
hdl/cpu_pkg.sv
hdl/mem_pkg.sv
hdl/sram_bank.sv
hdl/bank_router.sv
hdl/lane_merge.sv
hdl/ldst_unit.sv
hdl/data_mem_top.sv
verification/tb_data_mem.sv
